//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_unit_tb
FILELIST  ?= rename_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
SOURCES   := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/commit_stage.sv
`timescale 1ns/1ns

module commit_stage import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // rob head
    input  logic      head_valid,
    input  logic      head_done,
    input  reg_addr_t head_rd,
    input  xlen_t     head_data,
    input  rob_idx_t  head_idx,
    output logic      retire,
    // one-cycle update toward rat_arf
    output logic      commit_valid,
    // external four-phase commit port
    output logic      commit_req,
    output reg_addr_t commit_rd,
    output xlen_t     commit_data,
    output rob_idx_t  commit_rob_idx,
    input  logic      commit_ack
);

    commit_state_e state_q;
    commit_state_e state_d;

    // head finished and nothing outstanding
    logic take_head;

    assign take_head = (state_q == COMMIT_IDLE) && head_valid && head_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            COMMIT_IDLE: begin
                if (take_head) begin
                    state_d = COMMIT_REQ;
                end
            end
            COMMIT_REQ: begin
                if (commit_ack) begin
                    state_d = COMMIT_WAIT_DROP;
                end
            end
            COMMIT_WAIT_DROP: begin
                // next retirement only after ack is gone
                if (!commit_ack) begin
                    state_d = COMMIT_IDLE;
                end
            end
            default: state_d = COMMIT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= COMMIT_IDLE;
            retire       <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            state_q      <= state_d;
            // pop and rat update pulse together with the rise of req
            retire       <= take_head;
            commit_valid <= take_head;
        end
    end

    // latched so the request stays stable after the pop
    always_ff @(posedge clk) begin
        if (take_head) begin
            commit_rd      <= head_rd;
            commit_data    <= head_data;
            commit_rob_idx <= head_idx;
        end
    end

    assign commit_req = (state_q == COMMIT_REQ);

endmodule

//--- design/dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // external four-phase dispatch port
    input  logic      disp_req,
    input  reg_addr_t disp_rd,
    input  reg_addr_t disp_rs1,
    input  reg_addr_t disp_rs2,
    output logic      disp_ack,
    output rob_idx_t  disp_rob_idx,
    output logic      rs1_ready,
    output xlen_t     rs1_value,
    output rob_idx_t  rs1_tag,
    output logic      rs2_ready,
    output xlen_t     rs2_value,
    output rob_idx_t  rs2_tag,
    // rob allocation
    output logic      alloc_valid,
    output reg_addr_t alloc_rd,
    input  rob_idx_t  alloc_idx,
    input  logic      rob_full,
    // rename and operand lookup
    output logic      rename_valid,
    output reg_addr_t rename_rd,
    output rob_idx_t  rename_idx,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  logic      rat_rs1_ready,
    input  xlen_t     rat_rs1_value,
    input  rob_idx_t  rat_rs1_tag,
    input  logic      rat_rs2_ready,
    input  xlen_t     rat_rs2_value,
    input  rob_idx_t  rat_rs2_tag
);

    disp_state_e state_q;
    disp_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            DISP_IDLE: begin
                // hold off while the rob has no free slot
                if (disp_req && !rob_full) begin
                    state_d = DISP_ALLOC;
                end
            end
            // single allocation cycle
            DISP_ALLOC: state_d = DISP_ACK;
            DISP_ACK: begin
                // release ack once the requester lets go
                if (!disp_req) begin
                    state_d = DISP_IDLE;
                end
            end
            default: state_d = DISP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= DISP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // operands looked up in ALLOC, before this rd gets its new tag
    always_ff @(posedge clk) begin
        if (state_q == DISP_ALLOC) begin
            disp_rob_idx <= alloc_idx;
            rs1_ready    <= rat_rs1_ready;
            rs1_value    <= rat_rs1_value;
            rs1_tag      <= rat_rs1_tag;
            rs2_ready    <= rat_rs2_ready;
            rs2_value    <= rat_rs2_value;
            rs2_tag      <= rat_rs2_tag;
        end
    end

    assign disp_ack = (state_q == DISP_ACK);

    // request fields are stable while disp_req is high
    assign rs1_addr = disp_rs1;
    assign rs2_addr = disp_rs2;

    // x0 still takes a rob slot, it just skips the rename
    assign alloc_valid  = (state_q == DISP_ALLOC);
    assign alloc_rd     = disp_rd;
    assign rename_valid = alloc_valid && (disp_rd != '0);
    assign rename_rd    = disp_rd;
    assign rename_idx   = alloc_idx;

endmodule

//--- design/rat_arf.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rat_arf import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // new producer from dispatch
    input  logic      rename_valid,
    input  reg_addr_t rename_rd,
    input  rob_idx_t  rename_idx,
    // retired result from commit
    input  logic      commit_valid,
    input  reg_addr_t commit_rd,
    input  xlen_t     commit_data,
    input  rob_idx_t  commit_idx,
    // operand lookup
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output logic      rs1_ready,
    output xlen_t     rs1_value,
    output rob_idx_t  rs1_tag,
    output logic      rs2_ready,
    output xlen_t     rs2_value,
    output rob_idx_t  rs2_tag
);

    localparam int unsigned NUM_REGS = `RENAME_NUM_REGS;

    // per register state
    xlen_t    value_q [NUM_REGS];
    logic     ready_q [NUM_REGS];
    rob_idx_t tag_q   [NUM_REGS];

    // two read ports share one lookup
    reg_addr_t rd_addr  [2];
    logic      rd_ready [2];
    xlen_t     rd_value [2];
    rob_idx_t  rd_tag   [2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                value_q[i] <= '0;
                ready_q[i] <= 1'b1;
                tag_q[i]   <= '0;
            end
        end else begin
            // value always lands, ready only if no newer producer
            if (commit_valid && (commit_rd != '0)) begin
                value_q[commit_rd] <= commit_data;
                if (tag_q[commit_rd] == commit_idx) begin
                    ready_q[commit_rd] <= 1'b1;
                end
            end
            // later assignment so a same-cycle rename keeps ready low
            if (rename_valid && (rename_rd != '0)) begin
                ready_q[rename_rd] <= 1'b0;
                tag_q[rename_rd]   <= rename_idx;
            end
        end
    end

    assign rd_addr[0] = rs1_addr;
    assign rd_addr[1] = rs2_addr;

    for (genvar p = 0; p < 2; p++) begin : g_read
        always_comb begin
            rd_ready[p] = ready_q[rd_addr[p]];
            rd_value[p] = value_q[rd_addr[p]];
            rd_tag[p]   = tag_q[rd_addr[p]];
            // retirement in flight for the latest producer
            if (!ready_q[rd_addr[p]] && commit_valid && (commit_rd == rd_addr[p])
                && (commit_idx == tag_q[rd_addr[p]])) begin
                rd_ready[p] = 1'b1;
                rd_value[p] = commit_data;
            end
        end
    end

    assign rs1_ready = rd_ready[0];
    assign rs1_value = rd_value[0];
    assign rs1_tag   = rd_tag[0];
    assign rs2_ready = rd_ready[1];
    assign rs2_value = rd_value[1];
    assign rs2_tag   = rd_tag[1];

endmodule

//--- design/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    // one register value
    typedef logic [`RENAME_XLEN-1:0] xlen_t;

    // architectural register number
    // x0 reads as zero and is never renamed
    typedef logic [4:0] reg_addr_t;

    // rob slot number, doubles as the rename tag
    typedef logic [`RENAME_ROB_IDX_W-1:0] rob_idx_t;

    // dispatch side of the four-phase handshake
    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_ALLOC,
        DISP_ACK
    } disp_state_e;

    // commit side of the four-phase handshake
    typedef enum logic [1:0] {
        COMMIT_IDLE,
        COMMIT_REQ,
        COMMIT_WAIT_DROP
    } commit_state_e;

endpackage

//--- design/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// width of one register value
`define RENAME_XLEN 32

// architectural registers, x0 included
`define RENAME_NUM_REGS 32

// reorder buffer entries, power of two only
`define RENAME_ROB_DEPTH 8

// log2 of the rob depth, also the rename tag width
`define RENAME_ROB_IDX_W 3

`endif

//--- design/rename_unit.sv
`timescale 1ns/1ns

module rename_unit import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // dispatch handshake
    input  logic      disp_req,
    input  reg_addr_t disp_rd,
    input  reg_addr_t disp_rs1,
    input  reg_addr_t disp_rs2,
    output logic      disp_ack,
    output rob_idx_t  disp_rob_idx,
    output logic      rs1_ready,
    output xlen_t     rs1_value,
    output rob_idx_t  rs1_tag,
    output logic      rs2_ready,
    output xlen_t     rs2_value,
    output rob_idx_t  rs2_tag,
    // execution writeback
    input  logic      wb_valid,
    input  rob_idx_t  wb_rob_idx,
    input  xlen_t     wb_data,
    // commit handshake
    output logic      commit_req,
    output reg_addr_t commit_rd,
    output xlen_t     commit_data,
    output rob_idx_t  commit_rob_idx,
    input  logic      commit_ack
);

    // dispatch to rob
    logic      alloc_valid;
    reg_addr_t alloc_rd;
    rob_idx_t  alloc_idx;
    logic      rob_full;

    // dispatch to rat_arf
    logic      rename_valid;
    reg_addr_t rename_rd;
    rob_idx_t  rename_idx;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      rat_rs1_ready;
    xlen_t     rat_rs1_value;
    rob_idx_t  rat_rs1_tag;
    logic      rat_rs2_ready;
    xlen_t     rat_rs2_value;
    rob_idx_t  rat_rs2_tag;

    // rob head to commit
    logic      head_valid;
    logic      head_done;
    reg_addr_t head_rd;
    xlen_t     head_data;
    rob_idx_t  head_idx;
    logic      retire;

    // commit to rat_arf, data fields shared with the external port
    logic      commit_valid;

    dispatch_stage dispatch_i (
        .clk          (clk),
        .rst          (rst),
        .disp_req     (disp_req),
        .disp_rd      (disp_rd),
        .disp_rs1     (disp_rs1),
        .disp_rs2     (disp_rs2),
        .disp_ack     (disp_ack),
        .disp_rob_idx (disp_rob_idx),
        .rs1_ready    (rs1_ready),
        .rs1_value    (rs1_value),
        .rs1_tag      (rs1_tag),
        .rs2_ready    (rs2_ready),
        .rs2_value    (rs2_value),
        .rs2_tag      (rs2_tag),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .alloc_idx    (alloc_idx),
        .rob_full     (rob_full),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_idx   (rename_idx),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rat_rs1_ready(rat_rs1_ready),
        .rat_rs1_value(rat_rs1_value),
        .rat_rs1_tag  (rat_rs1_tag),
        .rat_rs2_ready(rat_rs2_ready),
        .rat_rs2_value(rat_rs2_value),
        .rat_rs2_tag  (rat_rs2_tag)
    );

    rat_arf rat_arf_i (
        .clk          (clk),
        .rst          (rst),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_idx   (rename_idx),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .commit_idx   (commit_rob_idx),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_ready    (rat_rs1_ready),
        .rs1_value    (rat_rs1_value),
        .rs1_tag      (rat_rs1_tag),
        .rs2_ready    (rat_rs2_ready),
        .rs2_value    (rat_rs2_value),
        .rs2_tag      (rat_rs2_tag)
    );

    rob rob_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_rd    (alloc_rd),
        .alloc_idx   (alloc_idx),
        .rob_full    (rob_full),
        .wb_valid    (wb_valid),
        .wb_rob_idx  (wb_rob_idx),
        .wb_data     (wb_data),
        .head_valid  (head_valid),
        .head_done   (head_done),
        .head_rd     (head_rd),
        .head_data   (head_data),
        .head_idx    (head_idx),
        .retire      (retire)
    );

    commit_stage commit_i (
        .clk            (clk),
        .rst            (rst),
        .head_valid     (head_valid),
        .head_done      (head_done),
        .head_rd        (head_rd),
        .head_data      (head_data),
        .head_idx       (head_idx),
        .retire         (retire),
        .commit_valid   (commit_valid),
        .commit_req     (commit_req),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_rob_idx (commit_rob_idx),
        .commit_ack     (commit_ack)
    );

endmodule

//--- design/rob.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rob import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // allocation at the tail
    input  logic      alloc_valid,
    input  reg_addr_t alloc_rd,
    output rob_idx_t  alloc_idx,
    output logic      rob_full,
    // execution writeback strobe
    input  logic      wb_valid,
    input  rob_idx_t  wb_rob_idx,
    input  xlen_t     wb_data,
    // oldest entry for commit
    output logic      head_valid,
    output logic      head_done,
    output reg_addr_t head_rd,
    output xlen_t     head_data,
    output rob_idx_t  head_idx,
    input  logic      retire
);

    localparam int unsigned DEPTH = `RENAME_ROB_DEPTH;

    // occupancy needs one bit more than the index
    typedef logic [`RENAME_ROB_IDX_W:0] rob_cnt_t;
    localparam rob_cnt_t FULL_CNT = rob_cnt_t'(DEPTH);

    // entry control
    logic busy_q [DEPTH];
    logic done_q [DEPTH];

    // entry payload
    reg_addr_t rd_q   [DEPTH];
    xlen_t     data_q [DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                busy_q[i] <= 1'b0;
                done_q[i] <= 1'b0;
            end
        end else begin
            if (alloc_valid) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + rob_idx_t'(1);
            end
            // stray strobe to a free slot is dropped
            if (wb_valid && busy_q[wb_rob_idx]) begin
                done_q[wb_rob_idx] <= 1'b1;
            end
            if (retire) begin
                busy_q[head_q] <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + rob_idx_t'(1);
            end
            // pointers wrap on their own, depth is a power of two
            if (alloc_valid && !retire) begin
                count_q <= count_q + rob_cnt_t'(1);
            end else if (retire && !alloc_valid) begin
                count_q <= count_q - rob_cnt_t'(1);
            end
        end
    end

    // payload writes
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (wb_valid && busy_q[wb_rob_idx]) begin
            data_q[wb_rob_idx] <= wb_data;
        end
    end

    assign alloc_idx = tail_q;
    assign rob_full  = (count_q == FULL_CNT);

    assign head_valid = busy_q[head_q];
    assign head_done  = done_q[head_q];
    assign head_rd    = rd_q[head_q];
    assign head_data  = data_q[head_q];
    assign head_idx   = head_q;

endmodule

//--- rename_unit.f
+incdir+design
design/rename_pkg.sv
design/dispatch_stage.sv
design/rat_arf.sv
design/rob.sv
design/commit_stage.sv
design/rename_unit.sv
test/rename_unit_tb.sv

//--- test/rename_unit_tb.sv
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_unit_tb import rename_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int BLOCK_WATCH    = 12;
    localparam int NUM_REGS       = `RENAME_NUM_REGS;

    // row modes
    localparam int MODE_RUN   = 0;
    localparam int MODE_HOLD  = 1;
    localparam int MODE_BLOCK = 2;

    logic      clk;
    logic      rst;
    logic      disp_req;
    reg_addr_t disp_rd;
    reg_addr_t disp_rs1;
    reg_addr_t disp_rs2;
    logic      disp_ack;
    rob_idx_t  disp_rob_idx;
    logic      rs1_ready;
    xlen_t     rs1_value;
    rob_idx_t  rs1_tag;
    logic      rs2_ready;
    xlen_t     rs2_value;
    rob_idx_t  rs2_tag;
    logic      wb_valid;
    rob_idx_t  wb_rob_idx;
    xlen_t     wb_data;
    logic      commit_req;
    reg_addr_t commit_rd;
    xlen_t     commit_data;
    rob_idx_t  commit_rob_idx;
    logic      commit_ack;

    // stimulus table with one entry per instruction
    reg_addr_t tbl_rd    [$];
    reg_addr_t tbl_rs1   [$];
    reg_addr_t tbl_rs2   [$];
    int        tbl_delay [$];
    xlen_t     tbl_value [$];
    bit        tbl_rnd   [$];
    int        tbl_mode  [$];

    // per row progress
    xlen_t    row_data [$];
    rob_idx_t row_idx  [$];
    bit       row_wb   [$];
    int       row_cnt  [$];

    // reference register state
    xlen_t    model_val [NUM_REGS];
    logic     model_rdy [NUM_REGS];
    rob_idx_t model_tag [NUM_REGS];
    rob_idx_t next_idx;

    // rows waiting to commit in dispatch order
    int commit_q [$];

    logic [31:0] lcg_state;

    rename_unit dut_i (
        .clk            (clk),
        .rst            (rst),
        .disp_req       (disp_req),
        .disp_rd        (disp_rd),
        .disp_rs1       (disp_rs1),
        .disp_rs2       (disp_rs2),
        .disp_ack       (disp_ack),
        .disp_rob_idx   (disp_rob_idx),
        .rs1_ready      (rs1_ready),
        .rs1_value      (rs1_value),
        .rs1_tag        (rs1_tag),
        .rs2_ready      (rs2_ready),
        .rs2_value      (rs2_value),
        .rs2_tag        (rs2_tag),
        .wb_valid       (wb_valid),
        .wb_rob_idx     (wb_rob_idx),
        .wb_data        (wb_data),
        .commit_req     (commit_req),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_rob_idx (commit_rob_idx),
        .commit_ack     (commit_ack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns %s got x%0d expected x%0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t ns %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    // inputs change and outputs are read just after the edge
    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_disp_ack(input logic level);
        int n;
        n = 0;
        while (disp_ack !== level) begin
            if (n == TIMEOUT_CYCLES) begin
                abort_run($sformatf("disp_ack did not go to %b in time", level));
            end
            step();
            n++;
        end
    endtask

    task automatic wait_commit_req(input logic level);
        int n;
        n = 0;
        while (commit_req !== level) begin
            if (n == TIMEOUT_CYCLES) begin
                abort_run($sformatf("commit_req did not go to %b in time", level));
            end
            step();
            n++;
        end
    endtask

    task automatic add_row(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                           input int delay, input xlen_t value, input bit rnd, input int mode);
        tbl_rd.push_back(rd);
        tbl_rs1.push_back(rs1);
        tbl_rs2.push_back(rs2);
        tbl_delay.push_back(delay);
        tbl_value.push_back(value);
        tbl_rnd.push_back(rnd);
        tbl_mode.push_back(mode);
        row_data.push_back('0);
        row_idx.push_back('0);
        row_wb.push_back(1'b0);
        row_cnt.push_back(0);
    endtask

    // rd, rs1, rs2, wb delay in dispatches, value, random, mode
    task automatic load_table();
        // fresh registers read as ready zero
        add_row(5'd1,  5'd2,  5'd3,  0, 32'h0000_0011, 1'b0, MODE_RUN);
        // dependency chain whose writebacks return as rows 3 2 4 1
        add_row(5'd5,  5'd1,  5'd4,  3, 32'h0,         1'b1, MODE_RUN);
        add_row(5'd6,  5'd5,  5'd7,  1, 32'h0,         1'b1, MODE_RUN);
        add_row(5'd7,  5'd6,  5'd5,  0, 32'h0000_0077, 1'b0, MODE_RUN);
        add_row(5'd8,  5'd7,  5'd1,  0, 32'h0,         1'b1, MODE_RUN);
        // two producers of x9 where the older one commits first
        add_row(5'd9,  5'd5,  5'd6,  1, 32'h0000_9a9a, 1'b0, MODE_RUN);
        add_row(5'd9,  5'd9,  5'd8,  3, 32'h0000_9b9b, 1'b0, MODE_RUN);
        add_row(5'd10, 5'd9,  5'd8,  1, 32'h0,         1'b1, MODE_RUN);
        add_row(5'd11, 5'd9,  5'd10, 0, 32'h0,         1'b1, MODE_RUN);
        add_row(5'd12, 5'd9,  5'd11, 0, 32'h0,         1'b1, MODE_RUN);
        add_row(5'd13, 5'd9,  5'd12, 0, 32'h0,         1'b1, MODE_RUN);
        // x0 destination retires without touching x0
        add_row(5'd0,  5'd0,  5'd13, 0, 32'hdead_beef, 1'b0, MODE_RUN);
        add_row(5'd14, 5'd0,  5'd0,  0, 32'h0,         1'b1, MODE_RUN);
        // first commit stalls on commit_ack and eight more fill the rob
        add_row(5'd15, 5'd14, 5'd2,  0, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd16, 5'd14, 5'd9,  3, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd17, 5'd16, 5'd0,  1, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd18, 5'd17, 5'd16, 0, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd19, 5'd18, 5'd13, 2, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd20, 5'd19, 5'd17, 0, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd21, 5'd20, 5'd5,  1, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd22, 5'd21, 5'd18, 0, 32'h0,         1'b1, MODE_HOLD);
        add_row(5'd23, 5'd22, 5'd16, 0, 32'h0,         1'b1, MODE_HOLD);
        // ninth in flight stalls until commits resume
        add_row(5'd24, 5'd1,  5'd0,  0, 32'h0,         1'b1, MODE_BLOCK);
        add_row(5'd25, 5'd15, 5'd24, 2, 32'h0000_2525, 1'b0, MODE_RUN);
        add_row(5'd0,  5'd0,  5'd23, 0, 32'h0,         1'b1, MODE_RUN);
    endtask

    task automatic check_operand(input string name, input reg_addr_t addr, input logic got_rdy,
                                 input xlen_t got_val, input rob_idx_t got_tag);
        check_bit({name, "_ready"}, got_rdy, model_rdy[addr]);
        // value only matters when ready and tag only when pending
        if (model_rdy[addr]) begin
            check_xlen({name, "_value"}, got_val, model_val[addr]);
        end else begin
            check_idx({name, "_tag"}, got_tag, model_tag[addr]);
        end
    endtask

    task automatic start_dispatch(input int k);
        step();
        disp_req = 1'b1;
        disp_rd  = tbl_rd[k];
        disp_rs1 = tbl_rs1[k];
        disp_rs2 = tbl_rs2[k];
    endtask

    task automatic finish_dispatch(input int k);
        wait_disp_ack(1'b1);
        check_idx("disp_rob_idx", disp_rob_idx, next_idx);
        check_operand("rs1", tbl_rs1[k], rs1_ready, rs1_value, rs1_tag);
        check_operand("rs2", tbl_rs2[k], rs2_ready, rs2_value, rs2_tag);
        row_idx[k] = next_idx;
        next_idx = next_idx + rob_idx_t'(1);
        // x0 keeps its rob slot but is never renamed
        if (tbl_rd[k] != '0) begin
            model_rdy[tbl_rd[k]] = 1'b0;
            model_tag[tbl_rd[k]] = row_idx[k];
        end
        commit_q.push_back(k);
        disp_req = 1'b0;
        wait_disp_ack(1'b0);
    endtask

    task automatic send_writeback(input int j);
        step();
        wb_valid   = 1'b1;
        wb_rob_idx = row_idx[j];
        wb_data    = row_data[j];
        row_wb[j]  = 1'b1;
        step();
        wb_valid = 1'b0;
    endtask

    // newest first so equal delays still land out of order
    task automatic issue_writebacks(input int k);
        for (int j = k; j >= 0; j--) begin
            if (!row_wb[j]) begin
                if (row_cnt[j] == 0) begin
                    send_writeback(j);
                end else begin
                    row_cnt[j]--;
                end
            end
        end
    endtask

    task automatic apply_commit(input int k);
        reg_addr_t rd;
        rd = tbl_rd[k];
        if (rd != '0) begin
            model_val[rd] = row_data[k];
            // a newer producer keeps the register pending
            if (model_tag[rd] == row_idx[k]) begin
                model_rdy[rd] = 1'b1;
            end
        end
    endtask

    // retire every written-back instruction at the front
    task automatic drain_commits();
        int k;
        while (commit_q.size() > 0 && row_wb[commit_q[0]]) begin
            k = commit_q.pop_front();
            wait_commit_req(1'b1);
            check_reg("commit_rd", commit_rd, tbl_rd[k]);
            check_xlen("commit_data", commit_data, row_data[k]);
            check_idx("commit_rob_idx", commit_rob_idx, row_idx[k]);
            apply_commit(k);
            commit_ack = 1'b1;
            wait_commit_req(1'b0);
            commit_ack = 1'b0;
        end
    endtask

    // rob full while the first commit waits for ack
    task automatic watch_blocked();
        for (int c = 0; c < BLOCK_WATCH; c++) begin
            step();
            check_bit("disp_ack", disp_ack, 1'b0);
        end
        check_bit("commit_req", commit_req, 1'b1);
    endtask

    initial begin
        rst        = 1'b1;
        disp_req   = 1'b0;
        disp_rd    = '0;
        disp_rs1   = '0;
        disp_rs2   = '0;
        wb_valid   = 1'b0;
        wb_rob_idx = '0;
        wb_data    = '0;
        commit_ack = 1'b0;
        lcg_state  = 32'h13eb_e367;
        next_idx   = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_val[reg_addr_t'(i)] = '0;
            model_rdy[reg_addr_t'(i)] = 1'b1;
            model_tag[reg_addr_t'(i)] = '0;
        end
        load_table();

        for (int c = 0; c < 8; c++) begin
            step();
        end
        rst = 1'b0;

        for (int k = 0; k < tbl_rd.size(); k++) begin
            if (tbl_rnd[k]) begin
                row_data[k] = lcg_next();
            end else begin
                row_data[k] = tbl_value[k];
            end
            row_cnt[k] = tbl_delay[k];
            start_dispatch(k);
            if (tbl_mode[k] == MODE_BLOCK) begin
                watch_blocked();
                fork
                    finish_dispatch(k);
                    drain_commits();
                join
            end else begin
                finish_dispatch(k);
            end
            issue_writebacks(k);
            if (tbl_mode[k] != MODE_HOLD) begin
                drain_commits();
            end
        end

        // leftover delays
        for (int j = 0; j < tbl_rd.size(); j++) begin
            if (!row_wb[j]) begin
                send_writeback(j);
            end
        end
        drain_commits();

        $display("TEST PASSED");
        $finish;
    end

endmodule
